// File: design/exu_consts.svh
`ifndef EXU_CONSTS_SVH
`define EXU_CONSTS_SVH

// integer datapath width
`define EXU_XLEN 32

// destination register index width
`define EXU_REG_ADDR_W 5

// in-order commit tag width, wide enough for the three stages in flight
`define EXU_COMMIT_ID_W 3

`endif

// File: design/exu_isa_pkg.sv
`default_nettype none

package exu_isa_pkg;

    // operations handled by the integer execute unit
    typedef enum logic [4:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLL,
        OP_SRL,
        OP_SRA,
        OP_SLT,
        OP_SLTU,
        OP_BEQ,
        OP_BNE,
        OP_BLT,
        OP_BGE,
        OP_BLTU,
        OP_BGEU,
        OP_JAL,
        OP_JALR,
        OP_MUL,
        OP_MULH,
        OP_MULHSU,
        OP_MULHU
    } exu_opcode_e;

    // functional unit that produces the result
    typedef enum logic [1:0] {
        UNIT_ALU,
        UNIT_BRU,
        UNIT_MUL
    } exu_unit_e;

endpackage

`default_nettype wire

// File: design/exu_pipe_pkg.sv
`default_nettype none

`include "exu_consts.svh"

package exu_pipe_pkg;

    import exu_isa_pkg::*;

    // one operation as presented by the caller
    typedef struct packed {
        exu_opcode_e                 opcode;
        logic [`EXU_XLEN-1:0]        op1;
        logic [`EXU_XLEN-1:0]        op2;
        logic [`EXU_XLEN-1:0]        imm;
        logic [`EXU_XLEN-1:0]        pc;
        logic [`EXU_REG_ADDR_W-1:0]  rd;
        logic [`EXU_COMMIT_ID_W-1:0] commit_id;
    } exu_req_t;

    // execute stage record
    typedef struct packed {
        exu_unit_e                   unit;
        // alu result or link address
        logic [`EXU_XLEN-1:0]        result;
        logic [`EXU_REG_ADDR_W-1:0]  rd;
        logic                        we;
        logic [`EXU_COMMIT_ID_W-1:0] commit_id;
        logic                        jump;
        logic [`EXU_XLEN-1:0]        jump_addr;
        logic                        misaligned;
        logic                        mul_hi;
    } exu_ex_t;

    // shared writeback port
    typedef struct packed {
        logic                        we;
        logic [`EXU_REG_ADDR_W-1:0]  rd;
        logic [`EXU_XLEN-1:0]        data;
        logic [`EXU_COMMIT_ID_W-1:0] commit_id;
        logic                        jump;
        logic [`EXU_XLEN-1:0]        jump_addr;
        logic                        misaligned;
    } exu_wb_t;

endpackage

`default_nettype wire

// File: design/exu_issue_stage.sv
`default_nettype none

module exu_issue_stage
    import exu_isa_pkg::*, exu_pipe_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      reset_i,
    input  wire logic      advance_i,
    input  wire logic      int_assert_i,
    input  wire logic      op_valid_i,
    input  wire exu_req_t  op_i,
    output logic           iss_valid_o,
    output exu_req_t       iss_o,
    output exu_unit_e      iss_unit_o
);

    exu_unit_e unit_dec;

    // unit decode, done once here so later stages switch on the unit
    always_comb begin
        case (op_i.opcode)
            OP_MUL, OP_MULH, OP_MULHSU, OP_MULHU: unit_dec = UNIT_MUL;
            OP_BEQ, OP_BNE, OP_BLT, OP_BGE,
            OP_BLTU, OP_BGEU, OP_JAL, OP_JALR:    unit_dec = UNIT_BRU;
            default:                              unit_dec = UNIT_ALU;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i || int_assert_i) begin
            iss_valid_o <= 1'b0;
        end else if (advance_i) begin
            iss_valid_o <= op_valid_i;
        end
    end

    // operation payload
    always_ff @(posedge clk) begin
        if (advance_i && op_valid_i) begin
            iss_o      <= op_i;
            iss_unit_o <= unit_dec;
        end
    end

endmodule

`default_nettype wire

// File: design/exu_bru.sv
`default_nettype none

`include "exu_consts.svh"

module exu_bru
    import exu_isa_pkg::*;
(
    input  wire exu_opcode_e          opcode_i,
    input  wire logic [`EXU_XLEN-1:0] op1_i,
    input  wire logic [`EXU_XLEN-1:0] op2_i,
    input  wire logic [`EXU_XLEN-1:0] imm_i,
    input  wire logic [`EXU_XLEN-1:0] pc_i,
    output logic                      taken_o,
    output logic [`EXU_XLEN-1:0]      target_o,
    output logic [`EXU_XLEN-1:0]      link_o,
    output logic                      misaligned_o
);

    localparam logic [`EXU_XLEN-1:0] INSN_BYTES = 4;

    logic                 op_eq;
    logic                 op_lt;
    logic                 op_ltu;
    logic [`EXU_XLEN-1:0] jalr_sum;

    assign op_eq  = (op1_i == op2_i);
    assign op_lt  = ($signed(op1_i) < $signed(op2_i));
    assign op_ltu = (op1_i < op2_i);

    always_comb begin
        case (opcode_i)
            OP_BEQ:          taken_o = op_eq;
            OP_BNE:          taken_o = !op_eq;
            OP_BLT:          taken_o = op_lt;
            OP_BGE:          taken_o = !op_lt;
            OP_BLTU:         taken_o = op_ltu;
            OP_BGEU:         taken_o = !op_ltu;
            OP_JAL, OP_JALR: taken_o = 1'b1;
            default:         taken_o = 1'b0;
        endcase
    end

    // jalr target is register based with bit 0 dropped
    assign jalr_sum = op1_i + imm_i;
    assign target_o = (opcode_i == OP_JALR) ? {jalr_sum[`EXU_XLEN-1:1], 1'b0}
                                            : pc_i + imm_i;

    assign link_o = pc_i + INSN_BYTES;

    // only 4-byte aligned fetch is supported
    assign misaligned_o = taken_o && target_o[1];

endmodule

`default_nettype wire

// File: design/exu_mul.sv
`default_nettype none

`include "exu_consts.svh"

module exu_mul
    import exu_isa_pkg::*;
(
    input  wire logic                 clk,
    input  wire logic                 reset_i,
    input  wire logic                 advance_i,
    input  wire exu_opcode_e          opcode_i,
    input  wire logic [`EXU_XLEN-1:0] op1_i,
    input  wire logic [`EXU_XLEN-1:0] op2_i,
    output logic [`EXU_XLEN-1:0]      product_o
);

    localparam int HALF = `EXU_XLEN / 2;
    localparam int PP_W = 2 * (HALF + 1);
    localparam int FULL_W = 2 * `EXU_XLEN;

    logic                     a_signed;
    logic                     b_signed;
    logic signed [`EXU_XLEN:0] a_ext;
    logic signed [`EXU_XLEN:0] b_ext;
    logic signed [HALF:0]     a_lo;
    logic signed [HALF:0]     a_hi;
    logic signed [HALF:0]     b_lo;
    logic signed [HALF:0]     b_hi;
    logic signed [PP_W-1:0]   pp_ll_q;
    logic signed [PP_W-1:0]   pp_lh_q;
    logic signed [PP_W-1:0]   pp_hl_q;
    logic signed [PP_W-1:0]   pp_hh_q;
    exu_opcode_e              opcode_q;
    logic [FULL_W-1:0]        sum;

    // mulh treats both operands as signed, mulhsu only the first
    assign a_signed = (opcode_i == OP_MULH) || (opcode_i == OP_MULHSU);
    assign b_signed = (opcode_i == OP_MULH);

    assign a_ext = {a_signed & op1_i[`EXU_XLEN-1], op1_i};
    assign b_ext = {b_signed & op2_i[`EXU_XLEN-1], op2_i};

    // low halves unsigned, high halves carry the sign
    assign a_lo = {1'b0, a_ext[HALF-1:0]};
    assign a_hi = a_ext[`EXU_XLEN:HALF];
    assign b_lo = {1'b0, b_ext[HALF-1:0]};
    assign b_hi = b_ext[`EXU_XLEN:HALF];

    // step one, partial products
    always_ff @(posedge clk) begin
        if (advance_i) begin
            pp_ll_q <= a_lo * b_lo;
            pp_lh_q <= a_lo * b_hi;
            pp_hl_q <= a_hi * b_lo;
            pp_hh_q <= a_hi * b_hi;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            opcode_q <= OP_MUL;
        end else if (advance_i) begin
            opcode_q <= opcode_i;
        end
    end

    // step two, weighted sum modulo 2^64
    assign sum = {{(FULL_W-PP_W){pp_ll_q[PP_W-1]}}, pp_ll_q}
               + ({{(FULL_W-PP_W){pp_lh_q[PP_W-1]}}, pp_lh_q} << HALF)
               + ({{(FULL_W-PP_W){pp_hl_q[PP_W-1]}}, pp_hl_q} << HALF)
               + ({{(FULL_W-PP_W){pp_hh_q[PP_W-1]}}, pp_hh_q} << `EXU_XLEN);

    assign product_o = (opcode_q == OP_MUL) ? sum[`EXU_XLEN-1:0]
                                            : sum[FULL_W-1:`EXU_XLEN];

endmodule

`default_nettype wire

// File: design/exu_ex_stage.sv
`default_nettype none

`include "exu_consts.svh"

module exu_ex_stage
    import exu_isa_pkg::*, exu_pipe_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       reset_i,
    input  wire logic       advance_i,
    input  wire logic       int_assert_i,
    input  wire logic       iss_valid_i,
    input  wire exu_req_t   iss_i,
    input  wire exu_unit_e  iss_unit_i,
    output logic            ex_valid_o,
    output exu_ex_t         ex_o,
    output logic [`EXU_XLEN-1:0] mul_product_o
);

    localparam int SHAMT_W = $clog2(`EXU_XLEN);

    logic [`EXU_XLEN-1:0] alu_result;
    logic [SHAMT_W-1:0]   shamt;
    logic                 bru_taken;
    logic [`EXU_XLEN-1:0] bru_target;
    logic [`EXU_XLEN-1:0] bru_link;
    logic                 bru_misaligned;
    logic                 is_jump;
    exu_ex_t              ex_d;

    exu_bru exu_bru_inst (
        .opcode_i     (iss_i.opcode),
        .op1_i        (iss_i.op1),
        .op2_i        (iss_i.op2),
        .imm_i        (iss_i.imm),
        .pc_i         (iss_i.pc),
        .taken_o      (bru_taken),
        .target_o     (bru_target),
        .link_o       (bru_link),
        .misaligned_o (bru_misaligned)
    );

    // first multiply step registers alongside the execute record
    exu_mul exu_mul_inst (
        .clk       (clk),
        .reset_i   (reset_i),
        .advance_i (advance_i),
        .opcode_i  (iss_i.opcode),
        .op1_i     (iss_i.op1),
        .op2_i     (iss_i.op2),
        .product_o (mul_product_o)
    );

    assign shamt = iss_i.op2[SHAMT_W-1:0];

    always_comb begin
        case (iss_i.opcode)
            OP_ADD:  alu_result = iss_i.op1 + iss_i.op2;
            OP_SUB:  alu_result = iss_i.op1 - iss_i.op2;
            OP_AND:  alu_result = iss_i.op1 & iss_i.op2;
            OP_OR:   alu_result = iss_i.op1 | iss_i.op2;
            OP_XOR:  alu_result = iss_i.op1 ^ iss_i.op2;
            OP_SLL:  alu_result = iss_i.op1 << shamt;
            OP_SRL:  alu_result = iss_i.op1 >> shamt;
            OP_SRA:  alu_result = $signed(iss_i.op1) >>> shamt;
            OP_SLT:  alu_result = {{(`EXU_XLEN-1){1'b0}},
                                   $signed(iss_i.op1) < $signed(iss_i.op2)};
            OP_SLTU: alu_result = {{(`EXU_XLEN-1){1'b0}}, iss_i.op1 < iss_i.op2};
            default: alu_result = '0;
        endcase
    end

    assign is_jump = (iss_i.opcode == OP_JAL) || (iss_i.opcode == OP_JALR);

    always_comb begin
        ex_d.unit      = iss_unit_i;
        ex_d.result    = (iss_unit_i == UNIT_BRU) ? bru_link : alu_result;
        ex_d.rd        = iss_i.rd;
        ex_d.commit_id = iss_i.commit_id;
        // x0 is never written, conditional branches write nothing
        if (iss_i.rd == '0) begin
            ex_d.we = 1'b0;
        end else if (iss_unit_i == UNIT_BRU) begin
            ex_d.we = is_jump;
        end else begin
            ex_d.we = 1'b1;
        end
        ex_d.jump       = bru_taken;
        ex_d.jump_addr  = bru_target;
        ex_d.misaligned = bru_misaligned;
        ex_d.mul_hi     = (iss_unit_i == UNIT_MUL) && (iss_i.opcode != OP_MUL);
    end

    always_ff @(posedge clk) begin
        if (reset_i || int_assert_i) begin
            ex_valid_o <= 1'b0;
        end else if (advance_i) begin
            ex_valid_o <= iss_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (advance_i && iss_valid_i) begin
            ex_o <= ex_d;
        end
    end

endmodule

`default_nettype wire

// File: design/exu_wb_stage.sv
`default_nettype none

`include "exu_consts.svh"

module exu_wb_stage
    import exu_isa_pkg::*, exu_pipe_pkg::*;
(
    input  wire logic                 clk,
    input  wire logic                 reset_i,
    input  wire logic                 int_assert_i,
    input  wire logic                 ex_valid_i,
    input  wire exu_ex_t              ex_i,
    input  wire logic [`EXU_XLEN-1:0] mul_product_i,
    input  wire logic                 wb_ready_i,
    output logic                      advance_o,
    output logic                      wb_valid_o,
    output exu_wb_t                   wb_o
);

    exu_wb_t wb_d;

    // whole pipeline moves when the output slot is free or draining
    assign advance_o = !wb_valid_o || wb_ready_i;

    // multiply product finishes here, second step of the multiplier
    always_comb begin
        wb_d.we         = ex_i.we;
        wb_d.rd         = ex_i.rd;
        wb_d.data       = (ex_i.unit == UNIT_MUL) ? mul_product_i : ex_i.result;
        wb_d.commit_id  = ex_i.commit_id;
        wb_d.jump       = ex_i.jump;
        wb_d.jump_addr  = ex_i.jump_addr;
        wb_d.misaligned = ex_i.misaligned;
    end

    // flush wins even over a transfer at the same edge
    always_ff @(posedge clk) begin
        if (reset_i || int_assert_i) begin
            wb_valid_o <= 1'b0;
        end else if (advance_o) begin
            wb_valid_o <= ex_valid_i;
        end
    end

    // held while stalled so wb_o stays stable
    always_ff @(posedge clk) begin
        if (advance_o && ex_valid_i) begin
            wb_o <= wb_d;
        end
    end

endmodule

`default_nettype wire

// File: design/exu_top.sv
`default_nettype none

`include "exu_consts.svh"

module exu_top
    import exu_isa_pkg::*, exu_pipe_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     reset_i,
    input  wire logic     op_valid_i,
    input  wire exu_req_t op_i,
    input  wire logic     int_assert_i,
    input  wire logic     wb_ready_i,
    output logic          op_ready_o,
    output logic          wb_valid_o,
    output exu_wb_t       wb_o
);

    logic                 advance;
    logic                 iss_valid;
    exu_req_t             iss;
    exu_unit_e            iss_unit;
    logic                 ex_valid;
    exu_ex_t              ex;
    logic [`EXU_XLEN-1:0] mul_product;

    assign op_ready_o = advance;

    exu_issue_stage exu_issue_stage_inst (
        .clk          (clk),
        .reset_i      (reset_i),
        .advance_i    (advance),
        .int_assert_i (int_assert_i),
        .op_valid_i   (op_valid_i),
        .op_i         (op_i),
        .iss_valid_o  (iss_valid),
        .iss_o        (iss),
        .iss_unit_o   (iss_unit)
    );

    exu_ex_stage exu_ex_stage_inst (
        .clk           (clk),
        .reset_i       (reset_i),
        .advance_i     (advance),
        .int_assert_i  (int_assert_i),
        .iss_valid_i   (iss_valid),
        .iss_i         (iss),
        .iss_unit_i    (iss_unit),
        .ex_valid_o    (ex_valid),
        .ex_o          (ex),
        .mul_product_o (mul_product)
    );

    exu_wb_stage exu_wb_stage_inst (
        .clk           (clk),
        .reset_i       (reset_i),
        .int_assert_i  (int_assert_i),
        .ex_valid_i    (ex_valid),
        .ex_i          (ex),
        .mul_product_i (mul_product),
        .wb_ready_i    (wb_ready_i),
        .advance_o     (advance),
        .wb_valid_o    (wb_valid_o),
        .wb_o          (wb_o)
    );

endmodule

`default_nettype wire

// File: test/exu_props.sv
`default_nettype none

module exu_props
    import exu_pipe_pkg::*;
(
    input wire logic    clk,
    input wire logic    reset_i,
    input wire logic    int_assert_i,
    input wire logic    wb_ready_i,
    input wire logic    op_ready_o,
    input wire logic    wb_valid_o,
    input wire exu_wb_t wb_o
);

    timeunit 1ns;
    timeprecision 100ps;

    // result held while the consumer stalls, unless flushed
    assert property (@(posedge clk) disable iff (reset_i)
        wb_valid_o && !wb_ready_i && !int_assert_i |=> wb_valid_o && $stable(wb_o))
        else $error("wb_o changed while valid and not ready");

    assert property (@(posedge clk) int_assert_i |=> !wb_valid_o)
        else $error("wb_valid_o still high in the cycle after a flush");

    assert property (@(posedge clk) disable iff (reset_i)
        wb_valid_o |-> (!wb_o.misaligned || wb_o.jump))
        else $error("misaligned flag set on a result without a jump");

    // empty pipeline after reset accepts at once
    assert property (@(posedge clk) reset_i |=> op_ready_o)
        else $error("op_ready_o low in the cycle after reset");

endmodule

bind exu_top exu_props exu_props_inst (
    .clk          (clk),
    .reset_i      (reset_i),
    .int_assert_i (int_assert_i),
    .wb_ready_i   (wb_ready_i),
    .op_ready_o   (op_ready_o),
    .wb_valid_o   (wb_valid_o),
    .wb_o         (wb_o)
);

`default_nettype wire

// File: test/exu_tb.sv
`default_nettype none

`include "exu_consts.svh"

module exu_tb
    import exu_isa_pkg::*, exu_pipe_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam time CLK_PERIOD = 40ns;
    localparam int RESET_CYCLES = 2;
    localparam int LATENCY = 3;
    localparam logic [31:0] SEED = 32'haa8753a2;

    typedef struct packed {
        logic     is_flush;
        exu_req_t req;
        exu_wb_t  exp_wb;
    } stim_t;

    // one accepted operation waiting for its result
    typedef struct packed {
        exu_wb_t     exp_wb;
        logic        timed;
        logic [31:0] accept_cycle;
    } sb_entry_t;

    logic     clk;
    logic     reset_i;
    logic     op_valid_i;
    exu_req_t op_i;
    logic     int_assert_i;
    logic     wb_ready_i;
    logic     op_ready_o;
    logic     wb_valid_o;
    exu_wb_t  wb_o;

    exu_wb_t                     exp_cur;
    logic                        timed_cur;
    stim_t                       stim_q[$];
    sb_entry_t                   sb_q[$];
    logic [31:0]                 rng_state;
    logic [31:0]                 cycle;
    logic [`EXU_COMMIT_ID_W-1:0] next_id;
    logic                        random_ready;
    logic                        stim_loaded;
    int                          value_errors;
    int                          other_errors;
    int                          transfers;

    exu_top exu_top_inst (
        .clk          (clk),
        .reset_i      (reset_i),
        .op_valid_i   (op_valid_i),
        .op_i         (op_i),
        .int_assert_i (int_assert_i),
        .wb_ready_i   (wb_ready_i),
        .op_ready_o   (op_ready_o),
        .wb_valid_o   (wb_valid_o),
        .wb_o         (wb_o)
    );

    always #(CLK_PERIOD / 2) clk = !clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic print_summary();
        $display("results checked %0d, value errors %0d, other errors %0d",
                 transfers, value_errors, other_errors);
    endtask

    task automatic load_stimulus();
        int          fd;
        int          n;
        string       line;
        logic [31:0] col[11];
        stim_t       s;
        fd = $fopen("test/exu_stim.txt", "r");
        if (fd == 0) begin
            other_errors++;
            $display("cannot open stimulus file test/exu_stim.txt");
        end else begin
            while (!$feof(fd)) begin
                n = $fgets(line, fd);
                s = '0;
                if (n > 0 && line.getc(0) == "F") begin
                    s.is_flush = 1'b1;
                    stim_q.push_back(s);
                end else if (n > 0 && line.getc(0) == "O") begin
                    n = $sscanf(line, "O %h %h %h %h %h %h %h %h %h %h %h", col[0], col[1],
                                col[2], col[3], col[4], col[5], col[6], col[7], col[8],
                                col[9], col[10]);
                    if (n != 11) begin
                        other_errors++;
                        $display("malformed stimulus line: %s", line);
                    end else begin
                        s.req.opcode         = exu_opcode_e'(col[0][4:0]);
                        s.req.op1            = col[1];
                        s.req.op2            = col[2];
                        s.req.imm            = col[3];
                        s.req.pc             = col[4];
                        s.req.rd             = col[5][`EXU_REG_ADDR_W-1:0];
                        s.exp_wb.rd          = col[5][`EXU_REG_ADDR_W-1:0];
                        s.exp_wb.we          = col[6][0];
                        s.exp_wb.data        = col[7];
                        s.exp_wb.jump        = col[8][0];
                        s.exp_wb.jump_addr   = col[9];
                        s.exp_wb.misaligned  = col[10][0];
                        stim_q.push_back(s);
                    end
                end
            end
            $fclose(fd);
        end
        stim_loaded = 1'b1;
    endtask

    // one rising edge and a new random ready level in the random pass
    task automatic tick();
        @(posedge clk);
        if (random_ready) begin
            rng_state = lcg_next(rng_state);
            wb_ready_i <= (rng_state[31:30] != 2'b00);
        end
    endtask

    task automatic send_op(input stim_t s, input logic timed);
        exu_req_t req;
        exu_wb_t  exp_wb;
        logic     accepted;
        req = s.req;
        req.commit_id = next_id;
        exp_wb = s.exp_wb;
        exp_wb.commit_id = next_id;
        op_valid_i <= 1'b1;
        op_i <= req;
        exp_cur <= exp_wb;
        timed_cur <= timed;
        accepted = 1'b0;
        // hold the operation until the edge that takes it
        while (!accepted) begin
            tick();
            accepted = op_ready_o;
        end
        next_id = next_id + 1'b1;
    endtask

    task automatic flush_pipeline();
        op_valid_i <= 1'b0;
        int_assert_i <= 1'b1;
        tick();
        int_assert_i <= 1'b0;
    endtask

    // idle until the scoreboard is empty, ending on a rising edge
    task automatic drain_results();
        op_valid_i <= 1'b0;
        @(negedge clk);
        while (sb_q.size() != 0) begin
            tick();
            @(negedge clk);
        end
        tick();
    endtask

    task automatic run_pass(input logic random_mode);
        random_ready = random_mode;
        for (int i = 0; i < stim_q.size(); i++) begin
            if (random_mode) begin
                rng_state = lcg_next(rng_state);
                if (rng_state[31:30] == 2'b00) begin
                    op_valid_i <= 1'b0;
                    repeat (rng_state[29:28] + 1) tick();
                end
            end
            if (stim_q[i].is_flush) begin
                // empty pipeline here so the operations flushed in the first pass get checked
                if (random_mode) begin
                    drain_results();
                end
                flush_pipeline();
            end else begin
                send_op(stim_q[i], !random_mode);
            end
        end
        drain_results();
        // a few idle edges so a duplicate result would show up
        repeat (4) tick();
        random_ready = 1'b0;
        wb_ready_i <= 1'b1;
    endtask

    task automatic compare_field(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        assert (actual === expected) else begin
            value_errors++;
            $display("[FAIL] %0t %s expected %h got %h", $time, name, expected, actual);
        end
    endtask

    task automatic check_result(input sb_entry_t head);
        compare_field("wb_o.commit_id", head.exp_wb.commit_id, wb_o.commit_id);
        compare_field("wb_o.we", head.exp_wb.we, wb_o.we);
        compare_field("wb_o.rd", head.exp_wb.rd, wb_o.rd);
        compare_field("wb_o.jump", head.exp_wb.jump, wb_o.jump);
        compare_field("wb_o.misaligned", head.exp_wb.misaligned, wb_o.misaligned);
        if (head.exp_wb.we) begin
            compare_field("wb_o.data", head.exp_wb.data, wb_o.data);
        end
        if (head.exp_wb.jump) begin
            compare_field("wb_o.jump_addr", head.exp_wb.jump_addr, wb_o.jump_addr);
        end
        if (head.timed) begin
            assert (cycle - head.accept_cycle == LATENCY) else begin
                other_errors++;
                $display("%0t: result with commit id %0d took %0d edges instead of %0d",
                         $time, wb_o.commit_id, cycle - head.accept_cycle, LATENCY);
            end
        end
    endtask

    // scoreboard samples everything at the edge itself
    always @(posedge clk) begin : monitor
        sb_entry_t head;
        sb_entry_t entry;
        cycle = cycle + 1;
        if (!reset_i) begin
            if (wb_valid_o && wb_ready_i) begin
                transfers++;
                if (sb_q.size() == 0) begin
                    other_errors++;
                    $display("%0t: result with commit id %0d arrived with nothing outstanding",
                             $time, wb_o.commit_id);
                end else begin
                    head = sb_q.pop_front();
                    check_result(head);
                end
            end
            // a flush drops every operation still in flight
            if (int_assert_i) begin
                sb_q.delete();
            end else if (op_valid_i && op_ready_o) begin
                entry.exp_wb = exp_cur;
                entry.timed = timed_cur;
                entry.accept_cycle = cycle;
                sb_q.push_back(entry);
            end
        end
    end

    initial begin : watchdog
        int limit;
        wait (stim_loaded);
        limit = stim_q.size() * 20 + 200;
        #(limit * CLK_PERIOD);
        other_errors++;
        $display("watchdog timeout after %0d clock periods, %0d results still outstanding",
                 limit, sb_q.size());
        print_summary();
        $display("Verification failed");
        $finish;
    end

    initial begin
        clk = 1'b0;
        reset_i = 1'b1;
        op_valid_i = 1'b0;
        op_i = '0;
        int_assert_i = 1'b0;
        wb_ready_i = 1'b1;
        exp_cur = '0;
        timed_cur = 1'b0;
        next_id = '0;
        rng_state = SEED;
        random_ready = 1'b0;
        stim_loaded = 1'b0;
        cycle = '0;
        value_errors = 0;
        other_errors = 0;
        transfers = 0;
        load_stimulus();
        repeat (RESET_CYCLES) @(posedge clk);
        reset_i <= 1'b0;
        if (stim_q.size() == 0) begin
            other_errors++;
            $display("no operations found in the stimulus file");
        end else begin
            // back to back with latency checks first, random gaps and stalls second
            run_pass(1'b0);
            run_pass(1'b1);
        end
        print_summary();
        if (value_errors == 0 && other_errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: test/exu_stim.txt
# O opcode op1 op2 imm pc rd, then expected we data jump jump_addr misaligned, all hex
# F flushes the pipeline; opcodes in exu_opcode_e order (add = 00 ... mulhu = 15)
O 00 00000005 00000003 00000000 00001000 01 1 00000008 0 00000000 0
O 01 00000003 00000005 00000000 00001000 02 1 fffffffe 0 00000000 0
O 04 ffff0000 0ff00ff0 00000000 00001000 03 1 f00f0ff0 0 00000000 0
O 05 00000003 00000024 00000000 00001000 04 1 00000030 0 00000000 0
O 06 80000000 00000004 00000000 00001000 05 1 08000000 0 00000000 0
O 07 80000000 00000004 00000000 00001000 06 1 f8000000 0 00000000 0
O 08 ffffffff 00000001 00000000 00001000 07 1 00000001 0 00000000 0
O 09 ffffffff 00000001 00000000 00001000 08 1 00000000 0 00000000 0
O 00 00000001 00000001 00000000 00001000 00 0 00000000 0 00000000 0
O 02 f0f0f0f0 ff00ff00 00000000 00001000 09 1 f000f000 0 00000000 0
F
O 0a 00000007 00000007 00000010 00001000 00 0 00000000 1 00001010 0
O 0b 00000007 00000007 00000010 00001000 0a 0 00000000 0 00000000 0
O 0c ffffffff 00000001 fffffff8 00001000 0b 0 00000000 1 00000ff8 0
O 0d ffffffff 00000001 00000010 00001000 0c 0 00000000 0 00000000 0
O 0e 00000001 ffffffff 00000006 00002000 0d 0 00000000 1 00002006 1
O 0f ffffffff 00000001 00000020 00002000 0e 0 00000000 1 00002020 0
O 10 00000000 00000000 00000100 00003000 01 1 00003004 1 00003100 0
O 11 00004001 00000000 00000004 00003010 02 1 00003014 1 00004004 0
O 11 00004000 00000000 00000003 00003020 03 1 00003024 1 00004002 1
O 12 00000007 fffffffd 00000000 00000000 0f 1 ffffffeb 0 00000000 0
O 13 80000000 80000000 00000000 00000000 10 1 40000000 0 00000000 0
O 13 80000000 7fffffff 00000000 00000000 11 1 c0000000 0 00000000 0
O 14 ffffffff ffffffff 00000000 00000000 12 1 ffffffff 0 00000000 0
O 15 ffffffff ffffffff 00000000 00000000 13 1 fffffffe 0 00000000 0

// File: project.f
+incdir+design
design/exu_isa_pkg.sv
design/exu_pipe_pkg.sv
design/exu_issue_stage.sv
design/exu_bru.sv
design/exu_mul.sv
design/exu_ex_stage.sv
design/exu_wb_stage.sv
design/exu_top.sv
test/exu_props.sv
test/exu_tb.sv
